//--- include/pipe_ctrl_consts.svh
// pipeline control constants: widths, stage indices, CP0 bit positions, reset values, vectors
`ifndef pipe_ctrl_consts_svh
`define pipe_ctrl_consts_svh

// widths
`define stage_w 5
`define addr_w 32
`define word_w 32
`define exc_w 5
`define sel_w 2

// stage indices, IF is the oldest fetch slot and WB the last
`define stage_if 0
`define stage_id 1
`define stage_ex 2
`define stage_mem 3
`define stage_wb 4

// Status and Cause bit positions
`define status_bev 22
`define status_erl 2
`define status_exl 1
`define cause_iv 23

// reset values, core comes up in bootstrap mode with ERL set
`define status_reset 32'h0040_0004
`define cause_reset 32'h0000_0000
`define epc_reset 32'h0000_0000
`define error_epc_reset 32'h0000_0000

// exception vectors
`define normal_base 32'h8000_0000
`define normal_gen_exc 32'h8000_0180
`define normal_sp_intr 32'h8000_0200
`define boot_base 32'hbfc0_0200
`define boot_gen_exc 32'hbfc0_0380
`define boot_sp_intr 32'hbfc0_0400

`endif

//--- logic/pipe_ctrl_pkg.sv
// pipeline control types shared by the control blocks and the top level
`include "pipe_ctrl_consts.svh"

package pipe_ctrl_pkg;

    // one bit per stage, bit 0 is IF and bit 4 is WB
    typedef logic [`stage_w-1:0] stage_vec_t;

    // instruction address
    typedef logic [`addr_w-1:0] addr_t;

    // CP0 register word
    typedef logic [`word_w-1:0] word_t;

    // exception type as signalled by the MEM stage
    typedef enum logic [`exc_w-1:0] {
        none,
        intr,
        tlb_refill,
        tlb_invalid,
        tlb_modified,
        reserved_instr,
        overflow,
        trap,
        syscall,
        breakpoint,
        address_error,
        coproc_unusable,
        eret
    } exc_type_t;

    // target of a software CP0 write
    typedef enum logic [`sel_w-1:0] {
        status,
        cause,
        epc,
        error_epc
    } cp0_sel_t;

endpackage

//--- logic/cp0_view_if.sv
// CP0 exception view, register block to exception decoder
`timescale 1ns/10ps

interface cp0_view_if
    import pipe_ctrl_pkg::*;
();

    // Status and Cause bits that steer vector selection
    logic bev;
    logic exl;
    logic erl;
    logic iv;

    // return addresses for ERET
    addr_t epc;
    addr_t error_epc;

    // register block drives the view
    modport source (output bev, exl, erl, iv, epc, error_epc);

    // decoder only reads it
    modport sink (input bev, exl, erl, iv, epc, error_epc);

endinterface

//--- logic/exc_decode.sv
// exception decoder: picks the redirect address for the signalled exception
`timescale 1ns/10ps
`include "pipe_ctrl_consts.svh"

module exc_decode
    import pipe_ctrl_pkg::*;
(
    input  logic      exc_flag,
    input  exc_type_t exc_type,
    cp0_view_if.sink  view,
    output addr_t     flush_pc
);

    always_comb begin
        // no redirect unless an exception is flagged
        flush_pc = '0;
        if (exc_flag) begin
            case (exc_type)
                // interrupts, IV moves them to the special vector
                intr: begin
                    case ({view.bev, view.iv})
                        2'b00: flush_pc = `normal_gen_exc;
                        2'b01: flush_pc = `normal_sp_intr;
                        2'b10: flush_pc = `boot_gen_exc;
                        default: flush_pc = `boot_sp_intr;
                    endcase
                end

                // refill inside a handler falls back to the general vector
                tlb_refill: begin
                    case ({view.bev, view.exl})
                        2'b00: flush_pc = `normal_base;
                        2'b01: flush_pc = `normal_gen_exc;
                        2'b10: flush_pc = `boot_base;
                        default: flush_pc = `boot_gen_exc;
                    endcase
                end

                // everything else goes to the general vector
                tlb_invalid,
                tlb_modified,
                reserved_instr,
                overflow,
                trap,
                syscall,
                breakpoint,
                address_error,
                coproc_unusable: begin
                    flush_pc = view.bev ? `boot_gen_exc : `normal_gen_exc;
                end

                // return from error level first, then from exception level
                eret: begin
                    flush_pc = view.erl ? view.error_epc : view.epc;
                end

                default: begin
                    flush_pc = '0;
                end
            endcase
        end
    end

endmodule

//--- logic/stall_chain.sv
// stall chain: turns stage stall requests into stall and bubble flush vectors
`timescale 1ns/10ps
`include "pipe_ctrl_consts.svh"

module stall_chain
    import pipe_ctrl_pkg::*;
(
    input  logic       exc_flag,
    input  stage_vec_t streq,
    input  logic       ex_null,
    input  logic       mem_null,
    output stage_vec_t stall,
    output stage_vec_t flush
);

    // per-stage stalls, resolved from WB backward
    logic stall_if;
    logic stall_id;
    logic stall_ex;
    logic stall_mem;
    logic stall_wb;

    stage_vec_t stall_c;
    stage_vec_t flush_c;

    assign stall_wb  = streq[`stage_wb];
    assign stall_mem = streq[`stage_mem] | stall_wb;
    // an empty slot downstream absorbs the stall, so it does not back up
    assign stall_ex  = streq[`stage_ex] | streq[`stage_if] | (stall_mem & ~mem_null);
    assign stall_id  = streq[`stage_id] | streq[`stage_if] | (stall_ex & ~ex_null);
    // fetch holds whenever decode holds
    assign stall_if  = stall_id;

    always_comb begin
        stall_c = '0;
        stall_c[`stage_if]  = stall_if;
        stall_c[`stage_id]  = stall_id;
        stall_c[`stage_ex]  = stall_ex;
        stall_c[`stage_mem] = stall_mem;
        stall_c[`stage_wb]  = stall_wb;

        // bubble where the stage ahead holds but this one moves on
        flush_c = '0;
        flush_c[`stage_ex]  = stall_id & ~stall_ex;
        flush_c[`stage_mem] = stall_ex & ~stall_mem;
        flush_c[`stage_wb]  = stall_mem & ~stall_wb;
    end

    // exception overrides, whole pipe is flushed and nothing holds
    assign stall = exc_flag ? '0 : stall_c;
    assign flush = exc_flag ? '1 : flush_c;

endmodule

//--- logic/cp0_exc_regs.sv
// CP0 exception state: Status, Cause, EPC and ErrorEPC with exception, ERET and write update
`timescale 1ns/10ps
`include "pipe_ctrl_consts.svh"

module cp0_exc_regs
    import pipe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       exc_flag,
    input  exc_type_t  exc_type,
    input  addr_t      exc_pc,
    input  logic       cp0_we,
    input  cp0_sel_t   cp0_sel,
    input  word_t      cp0_wdata,
    cp0_view_if.source view,
    output word_t      status_out,
    output word_t      epc_out
);

    // architectural registers
    word_t status_q;
    word_t cause_q;
    word_t epc_q;
    word_t error_epc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q    <= `status_reset;
            cause_q     <= `cause_reset;
            epc_q       <= `epc_reset;
            error_epc_q <= `error_epc_reset;
        end else if (exc_flag) begin
            // exception has priority, a same-cycle write is dropped
            if (exc_type == eret) begin
                // leave error level first if both are set
                if (status_q[`status_erl]) begin
                    status_q[`status_erl] <= 1'b0;
                end else begin
                    status_q[`status_exl] <= 1'b0;
                end
            end else if (exc_type != none) begin
                // nested exception keeps the first return address
                if (!status_q[`status_exl]) begin
                    epc_q <= exc_pc;
                end
                status_q[`status_exl] <= 1'b1;
            end
        end else if (cp0_we) begin
            // software write, full word to the selected register
            case (cp0_sel)
                status: begin
                    status_q <= cp0_wdata;
                end
                cause: begin
                    cause_q <= cp0_wdata;
                end
                epc: begin
                    epc_q <= cp0_wdata;
                end
                default: begin
                    error_epc_q <= cp0_wdata;
                end
            endcase
        end
    end

    // decoded bits for the vector decoder
    assign view.bev       = status_q[`status_bev];
    assign view.exl       = status_q[`status_exl];
    assign view.erl       = status_q[`status_erl];
    assign view.iv        = cause_q[`cause_iv];
    assign view.epc       = epc_q;
    assign view.error_epc = error_epc_q;

    // observation ports
    assign status_out = status_q;
    assign epc_out    = epc_q;

endmodule

//--- logic/pipe_ctrl_top.sv
// pipeline control top: stall chain, exception decoder and CP0 exception state
`timescale 1ns/10ps

module pipe_ctrl_top
    import pipe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    // stall requests and empty-slot flags
    input  stage_vec_t streq,
    input  logic       ex_null,
    input  logic       mem_null,

    // exception from MEM
    input  logic       exc_flag,
    input  exc_type_t  exc_type,
    input  addr_t      exc_pc,

    // software CP0 write
    input  logic       cp0_we,
    input  cp0_sel_t   cp0_sel,
    input  word_t      cp0_wdata,

    // pipeline control
    output stage_vec_t stall,
    output stage_vec_t flush,
    output addr_t      flush_pc,

    // CP0 observation
    output word_t      status_out,
    output word_t      epc_out
);

    // CP0 bits seen by the decoder
    cp0_view_if u_view ();

    cp0_exc_regs u_cp0_exc_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .exc_flag   (exc_flag),
        .exc_type   (exc_type),
        .exc_pc     (exc_pc),
        .cp0_we     (cp0_we),
        .cp0_sel    (cp0_sel),
        .cp0_wdata  (cp0_wdata),
        .view       (u_view.source),
        .status_out (status_out),
        .epc_out    (epc_out)
    );

    // redirect address from current CP0 state, same cycle
    exc_decode u_exc_decode (
        .exc_flag (exc_flag),
        .exc_type (exc_type),
        .view     (u_view.sink),
        .flush_pc (flush_pc)
    );

    stall_chain u_stall_chain (
        .exc_flag (exc_flag),
        .streq    (streq),
        .ex_null  (ex_null),
        .mem_null (mem_null),
        .stall    (stall),
        .flush    (flush)
    );

endmodule

//--- sim/tb_pipe_ctrl.sv
// pipeline control testbench that replays a cycle trace and checks every output
`timescale 1ns/10ps

module tb_pipe_ctrl
    import pipe_ctrl_pkg::*;
();

    // nine input columns then five expected outputs per trace line
    localparam int n_cols = 14;
    localparam int max_lines = 64;

    logic       clk;
    logic       arst_n;
    stage_vec_t streq;
    logic       ex_null;
    logic       mem_null;
    logic       exc_flag;
    exc_type_t  exc_type;
    addr_t      exc_pc;
    logic       cp0_we;
    cp0_sel_t   cp0_sel;
    word_t      cp0_wdata;
    stage_vec_t stall;
    stage_vec_t flush;
    addr_t      flush_pc;
    word_t      status_out;
    word_t      epc_out;

    logic [31:0] trace_mem [0:max_lines-1][0:n_cols-1];
    int n_lines;
    int cur_line;
    int cycle_cnt = 0;
    int cycle_limit;

    pipe_ctrl_top u_dut (.*);

    // 20 ns period
    always #10 clk = ~clk;

    // watchdog stops the run once the cycle count reaches the limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: trace did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic check_stage(input string name, input stage_vec_t exp, input stage_vec_t act);
        if (act !== exp) begin
            $display("ERROR: %s at trace line %0d expected %h actual %h",
                     name, cur_line, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "stage vector mismatch");
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERROR: %s at trace line %0d expected %h actual %h",
                     name, cur_line, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERROR: %s at trace line %0d expected %h actual %h",
                     name, cur_line, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "register word mismatch");
        end
    endtask

    task automatic load_trace();
        int fd;
        int cnt;
        string line;
        fd = $fopen("sim/pipe_ctrl_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file sim/pipe_ctrl_trace.txt");
            $display("STATUS: FAIL");
            $fatal(1, "trace file missing");
        end
        n_lines = 0;
        while ($fgets(line, fd) != 0 && n_lines < max_lines) begin
            // comment and blank lines carry no cycle
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    trace_mem[n_lines][0], trace_mem[n_lines][1], trace_mem[n_lines][2],
                    trace_mem[n_lines][3], trace_mem[n_lines][4], trace_mem[n_lines][5],
                    trace_mem[n_lines][6], trace_mem[n_lines][7], trace_mem[n_lines][8],
                    trace_mem[n_lines][9], trace_mem[n_lines][10], trace_mem[n_lines][11],
                    trace_mem[n_lines][12], trace_mem[n_lines][13]);
                if (cnt != n_cols) begin
                    $display("trace line %0d does not hold %0d columns", n_lines + 1, n_cols);
                    $display("STATUS: FAIL");
                    $fatal(1, "malformed trace");
                end
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        streq     = '0;
        ex_null   = 1'b0;
        mem_null  = 1'b0;
        exc_flag  = 1'b0;
        exc_type  = none;
        exc_pc    = '0;
        cp0_we    = 1'b0;
        cp0_sel   = status;
        cp0_wdata = '0;
        load_trace();
        // limit covers reset and one cycle per trace line plus a margin of 20
        cycle_limit = n_lines + 2 + 20;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            cur_line = i + 1;
            streq     <= trace_mem[i][0][4:0];
            ex_null   <= trace_mem[i][1][0];
            mem_null  <= trace_mem[i][2][0];
            exc_flag  <= trace_mem[i][3][0];
            exc_type  <= exc_type_t'(trace_mem[i][4][4:0]);
            exc_pc    <= trace_mem[i][5];
            cp0_we    <= trace_mem[i][6][0];
            cp0_sel   <= cp0_sel_t'(trace_mem[i][7][1:0]);
            cp0_wdata <= trace_mem[i][8];

            // combinational outputs are stable by the falling edge
            @(negedge clk);
            check_stage("stall", trace_mem[i][9][4:0], stall);
            check_stage("flush", trace_mem[i][10][4:0], flush);
            check_addr("flush_pc", trace_mem[i][11], flush_pc);
            check_word("status_out", trace_mem[i][12], status_out);
            check_word("epc_out", trace_mem[i][13], epc_out);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
logic/pipe_ctrl_pkg.sv
logic/cp0_view_if.sv
logic/exc_decode.sv
logic/stall_chain.sv
logic/cp0_exc_regs.sv
logic/pipe_ctrl_top.sv
sim/tb_pipe_ctrl.sv

//--- sim/pipe_ctrl_trace.txt
# in:  streq ex_null mem_null exc_flag exc_type exc_pc cp0_we cp0_sel cp0_wdata (hex)
# exp: stall flush flush_pc status_out epc_out (hex), one line per cycle after reset
00 0 0 0 0 00000000 0 0 00000000 00 00 00000000 00400004 00000000
10 0 0 0 0 00000000 0 0 00000000 1f 00 00000000 00400004 00000000
08 0 0 0 0 00000000 0 0 00000000 0f 10 00000000 00400004 00000000
04 0 0 0 0 00000000 0 0 00000000 07 08 00000000 00400004 00000000
02 0 0 0 0 00000000 0 0 00000000 03 04 00000000 00400004 00000000
01 0 0 0 0 00000000 0 0 00000000 07 08 00000000 00400004 00000000
08 0 1 0 0 00000000 0 0 00000000 08 10 00000000 00400004 00000000
08 1 0 0 0 00000000 0 0 00000000 0c 10 00000000 00400004 00000000
12 0 0 0 0 00000000 0 0 00000000 1f 00 00000000 00400004 00000000
0a 0 1 0 0 00000000 0 0 00000000 0b 14 00000000 00400004 00000000
00 0 0 0 0 00000000 1 0 00000000 00 00 00000000 00400004 00000000
00 0 0 0 0 00000000 1 1 00800000 00 00 00000000 00000000 00000000
00 0 0 1 2 00400100 0 0 00000000 00 1f 80000000 00000000 00000000
00 0 0 1 1 00400200 0 0 00000000 00 1f 80000200 00000002 00400100
00 0 0 1 2 00400400 0 0 00000000 00 1f 80000180 00000002 00400100
1f 0 0 1 6 00400480 0 0 00000000 00 1f 80000180 00000002 00400100
00 0 0 1 c 00000000 0 0 00000000 00 1f 00400100 00000002 00400100
00 0 0 0 0 00000000 1 0 00400000 00 00 00000000 00000000 00400100
00 0 0 0 0 00000000 1 3 bfc00100 00 00 00000000 00400000 00400100
00 0 0 1 2 00400500 0 0 00000000 00 1f bfc00200 00400000 00400100
00 0 0 1 1 00400600 0 0 00000000 00 1f bfc00400 00400002 00400500
00 0 0 1 9 00400700 0 0 00000000 00 1f bfc00380 00400002 00400500
00 0 0 1 7 00400800 1 2 deadbeef 00 1f bfc00380 00400002 00400500
00 0 0 0 0 00000000 1 1 00000000 00 00 00000000 00400002 00400500
00 0 0 1 1 00400900 0 0 00000000 00 1f bfc00380 00400002 00400500
00 0 0 0 0 00000000 1 0 00400006 00 00 00000000 00400002 00400500
00 0 0 1 c 00000000 0 0 00000000 00 1f bfc00100 00400006 00400500
00 0 0 1 c 00000000 0 0 00000000 00 1f 00400500 00400002 00400500
00 0 0 1 0 12345678 0 0 00000000 00 1f 00000000 00400000 00400500
